//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam word_t INST_SIZE = 32'd4;

    // major opcodes, bits 6:0 of the instruction.
    localparam opcode_t OP     = 7'b0110011;
    localparam opcode_t OP_IMM = 7'b0010011;
    localparam opcode_t LUI    = 7'b0110111;
    localparam opcode_t AUIPC  = 7'b0010111;
    localparam opcode_t JAL    = 7'b1101111;
    localparam opcode_t JALR   = 7'b1100111;
    localparam opcode_t BRANCH = 7'b1100011;
    localparam opcode_t LOAD   = 7'b0000011;
    localparam opcode_t STORE  = 7'b0100011;

    localparam funct3_t F3_ADD     = 3'b000; // add and sub.
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // load and store sizes.
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_ALT = 7'h20; // selects sub and sra.

endpackage

`default_nettype wire

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM,
        MEM_WAIT,
        TRAPPED
    } state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui.
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} alu_src1_e;
    typedef enum logic {SRC2_RS2, SRC2_IMM} alu_src2_e;
    typedef enum logic [1:0] {RD_ALU, RD_MEM, RD_LINK} rd_sel_e;

endpackage

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  wire                 clk,
    input  wire                 rst,
    input  isa_pkg::reg_addr_t  rs1,
    input  isa_pkg::reg_addr_t  rs2,
    input  isa_pkg::reg_addr_t  rd,
    input  isa_pkg::word_t      wr_data,
    input  wire                 wr_en,
    output isa_pkg::word_t      rs1_data,
    output isa_pkg::word_t      rs2_data
);
    localparam int AW = $clog2(NUM_REGS);

    isa_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en && rd != '0) begin
            regs[rd[AW-1:0]] <= wr_data;
        end
    end

    // x0 is never written, but reads of it are forced to zero anyway.
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1[AW-1:0]];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2[AW-1:0]];

    // decode flags out of range indexes and control then traps instead of writing.
    a_wr_index: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> int'(rd) < NUM_REGS);

endmodule

`default_nettype wire

//--- verilog/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode #(
    parameter int NUM_REGS = 32
) (
    input  isa_pkg::word_t      ir,
    output isa_pkg::opcode_t    opcode,
    output isa_pkg::funct3_t    funct3,
    output isa_pkg::reg_addr_t  rd,
    output isa_pkg::reg_addr_t  rs1,
    output isa_pkg::reg_addr_t  rs2,
    output isa_pkg::word_t      imm,
    output core_pkg::alu_op_e   alu_op,
    output core_pkg::alu_src1_e src1,
    output core_pkg::alu_src2_e src2,
    output core_pkg::rd_sel_e   rd_sel,
    output logic                illegal
);
    logic [6:0] funct7;
    isa_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic bad_enc, use_rs1, use_rs2, use_rd;

    function automatic core_pkg::alu_op_e arith_op(isa_pkg::funct3_t f3, logic alt);
        case (f3)
            isa_pkg::F3_ADD:     return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     return core_pkg::ALU_SLL;
            isa_pkg::F3_SLT:     return core_pkg::ALU_SLT;
            isa_pkg::F3_SLTU:    return core_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:     return core_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            isa_pkg::F3_OR:      return core_pkg::ALU_OR;
            default:             return core_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        alu_op  = core_pkg::ALU_ADD;
        src1    = core_pkg::SRC1_RS1;
        src2    = core_pkg::SRC2_IMM;
        rd_sel  = core_pkg::RD_ALU;
        imm     = imm_i;
        bad_enc = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (opcode)
            isa_pkg::OP: begin
                alu_op  = arith_op(funct3, funct7[5]);
                src2    = core_pkg::SRC2_RS2;
                {use_rs1, use_rs2, use_rd} = 3'b111;
                if (funct7 == isa_pkg::FUNCT7_ALT)
                    bad_enc = funct3 != isa_pkg::F3_ADD && funct3 != isa_pkg::F3_SRL_SRA;
                else
                    bad_enc = funct7 != 7'h00;
            end
            isa_pkg::OP_IMM: begin
                alu_op  = arith_op(funct3, funct3 == isa_pkg::F3_SRL_SRA && funct7[5]);
                {use_rs1, use_rd} = 2'b11;
                if (funct3 == isa_pkg::F3_SLL)
                    bad_enc = funct7 != 7'h00;
                else if (funct3 == isa_pkg::F3_SRL_SRA)
                    bad_enc = funct7 != 7'h00 && funct7 != isa_pkg::FUNCT7_ALT;
            end
            isa_pkg::LUI: begin
                alu_op = core_pkg::ALU_PASS_B;
                imm    = imm_u;
                use_rd = 1'b1;
            end
            isa_pkg::AUIPC: begin
                src1   = core_pkg::SRC1_PC;
                imm    = imm_u;
                use_rd = 1'b1;
            end
            isa_pkg::JAL: begin
                rd_sel = core_pkg::RD_LINK;
                imm    = imm_j;
                use_rd = 1'b1;
            end
            isa_pkg::JALR: begin
                rd_sel  = core_pkg::RD_LINK; // target is rs1 + imm out of the alu.
                {use_rs1, use_rd} = 2'b11;
                bad_enc = funct3 != 3'b000;
            end
            isa_pkg::BRANCH: begin
                src2    = core_pkg::SRC2_RS2;
                imm     = imm_b;
                {use_rs1, use_rs2} = 2'b11;
                bad_enc = funct3[2:1] == 2'b01;
            end
            isa_pkg::LOAD: begin
                rd_sel  = core_pkg::RD_MEM;
                {use_rs1, use_rd} = 2'b11;
                bad_enc = funct3 == 3'b011 || funct3[2:1] == 2'b11;
            end
            isa_pkg::STORE: begin
                imm     = imm_s;
                {use_rs1, use_rs2} = 2'b11;
                bad_enc = funct3[2] || funct3[1:0] == 2'b11;
            end
            default: bad_enc = 1'b1;
        endcase
    end

    assign illegal = bad_enc
                   || (use_rs1 && int'(rs1) >= NUM_REGS)
                   || (use_rs2 && int'(rs2) >= NUM_REGS)
                   || (use_rd && int'(rd) >= NUM_REGS);

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  isa_pkg::word_t    a,
    input  isa_pkg::word_t    b,
    input  core_pkg::alu_op_e op,
    input  isa_pkg::funct3_t  funct3,
    output isa_pkg::word_t    result,
    output logic              branch_taken
);
    logic eq, lt, ltu;

    assign eq  = a == b;
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (op)
            core_pkg::ALU_SUB:    result = a - b;
            core_pkg::ALU_SLL:    result = a << b[4:0];
            core_pkg::ALU_SLT:    result = {31'b0, lt};
            core_pkg::ALU_SLTU:   result = {31'b0, ltu};
            core_pkg::ALU_XOR:    result = a ^ b;
            core_pkg::ALU_SRL:    result = a >> b[4:0];
            core_pkg::ALU_SRA:    result = $signed(a) >>> b[4:0];
            core_pkg::ALU_OR:     result = a | b;
            core_pkg::ALU_AND:    result = a & b;
            core_pkg::ALU_PASS_B: result = b;
            default:              result = a + b; // also address and jalr target.
        endcase
    end

    always_comb begin
        case (funct3)
            isa_pkg::F3_BEQ:  branch_taken = eq;
            isa_pkg::F3_BNE:  branch_taken = !eq;
            isa_pkg::F3_BLT:  branch_taken = lt;
            isa_pkg::F3_BGE:  branch_taken = !lt;
            isa_pkg::F3_BLTU: branch_taken = ltu;
            isa_pkg::F3_BGEU: branch_taken = !ltu;
            default:          branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control (
    input  wire              clk,
    input  wire              rst,
    input  isa_pkg::opcode_t opcode,
    input  wire              illegal,
    input  wire              target_misaligned,
    input  wire              misaligned,
    output logic             fetch,
    output logic             mem_read,
    output logic             mem_write,
    output logic             write_ir,
    output logic             write_pc,
    output logic             write_rd,
    output logic             trap
);
    core_pkg::state_e state, state_next;
    logic is_load, is_store, is_mem, fault, exec_ok;

    assign is_load  = opcode == isa_pkg::LOAD;
    assign is_store = opcode == isa_pkg::STORE;
    assign is_mem   = is_load || is_store;
    assign fault    = illegal || target_misaligned || (is_mem && misaligned);
    assign exec_ok  = state == core_pkg::EXECUTE && !fault && !is_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= core_pkg::FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            core_pkg::FETCH:      state_next = core_pkg::FETCH_WAIT;
            core_pkg::FETCH_WAIT: state_next = core_pkg::EXECUTE;
            core_pkg::EXECUTE: begin
                if (fault)
                    state_next = core_pkg::TRAPPED;
                else if (is_mem)
                    state_next = core_pkg::MEM;
                else
                    state_next = core_pkg::FETCH;
            end
            core_pkg::MEM:        state_next = is_load ? core_pkg::MEM_WAIT : core_pkg::FETCH;
            core_pkg::MEM_WAIT:   state_next = core_pkg::FETCH;
            default:              state_next = core_pkg::TRAPPED; // sticky until reset.
        endcase
    end

    assign fetch     = state == core_pkg::FETCH && !rst; // bus stays idle in reset.
    assign write_ir  = state == core_pkg::FETCH_WAIT;
    assign mem_read  = state == core_pkg::MEM && is_load;
    assign mem_write = state == core_pkg::MEM && is_store;
    assign write_pc  = exec_ok || mem_write || state == core_pkg::MEM_WAIT;
    // branch rd field holds immediate bits.
    assign write_rd  = (exec_ok && opcode != isa_pkg::BRANCH) || state == core_pkg::MEM_WAIT;
    assign trap      = state == core_pkg::TRAPPED;

    a_rd_ir_excl: assert property (@(posedge clk) disable iff (rst)
        !(write_rd && write_ir));

endmodule

`default_nettype wire

//--- verilog/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  wire              clk,
    input  wire              rst,
    input  wire              fetch,
    input  wire              mem_read,
    input  wire              mem_write,
    input  isa_pkg::word_t   pc,
    input  isa_pkg::word_t   addr,
    input  isa_pkg::word_t   store_data,
    input  isa_pkg::funct3_t funct3,
    input  isa_pkg::word_t   mem_rdata,
    output logic             mem_req,
    output logic             mem_we,
    output isa_pkg::word_t   mem_addr,
    output logic [3:0]       mem_be,
    output isa_pkg::word_t   mem_wdata,
    output isa_pkg::word_t   load_data,
    output logic             misaligned
);
    logic [1:0] off_q;
    isa_pkg::funct3_t size_q;
    isa_pkg::word_t lane;

    assign mem_req  = fetch || mem_read || mem_write;
    assign mem_we   = mem_write;
    assign mem_addr = fetch ? pc : addr;

    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                mem_be    = 4'b0001 << addr[1:0];
                mem_wdata = {4{store_data[7:0]}};
            end
            2'b01: begin
                mem_be    = 4'b0011 << addr[1:0];
                mem_wdata = {2{store_data[15:0]}};
            end
            default: begin
                mem_be    = 4'b1111;
                mem_wdata = store_data;
            end
        endcase
        if (fetch)
            mem_be = 4'b1111;
    end

    assign misaligned = (funct3[1:0] == 2'b01 && addr[0])
                     || (funct3[1:0] == 2'b10 && addr[1:0] != 2'b00);

    // read data returns a cycle later, so keep what is needed to align it.
    always_ff @(posedge clk) begin
        if (rst) begin
            off_q  <= '0;
            size_q <= isa_pkg::F3_WORD;
        end else if (mem_read) begin
            off_q  <= addr[1:0];
            size_q <= funct3;
        end
    end

    assign lane = mem_rdata >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            isa_pkg::F3_BYTE:   load_data = {{24{lane[7]}}, lane[7:0]};
            isa_pkg::F3_HALF:   load_data = {{16{lane[15]}}, lane[15:0]};
            isa_pkg::F3_BYTE_U: load_data = {24'b0, lane[7:0]};
            isa_pkg::F3_HALF_U: load_data = {16'b0, lane[15:0]};
            default:            load_data = mem_rdata;
        endcase
    end

    // control traps in execute, so a misaligned data strobe never goes out.
    a_no_misaligned_req: assert property (@(posedge clk) disable iff (rst)
        mem_req && !fetch |-> !misaligned);

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int             NUM_REGS     = 32,
    parameter isa_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  wire            clk,
    input  wire            rst,
    input  isa_pkg::word_t mem_rdata,
    output logic           mem_req,
    output logic           mem_we,
    output isa_pkg::word_t mem_addr,
    output logic [3:0]     mem_be,
    output isa_pkg::word_t mem_wdata,
    output logic           trap
);
    isa_pkg::word_t pc, ir, next_pc, pc_plus4, pc_target, jalr_target;
    isa_pkg::word_t imm, rs1_data, rs2_data, rd_data;
    isa_pkg::word_t alu_a, alu_b, alu_result, load_data;
    isa_pkg::opcode_t opcode;
    isa_pkg::funct3_t funct3;
    isa_pkg::reg_addr_t rd, rs1, rs2;
    core_pkg::alu_op_e alu_op;
    core_pkg::alu_src1_e src1;
    core_pkg::alu_src2_e src2;
    core_pkg::rd_sel_e rd_sel;
    logic illegal, branch_taken, misaligned, target_misaligned;
    logic fetch, mem_read, mem_write, write_ir, write_pc, write_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (write_pc) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (write_ir) begin
            ir <= mem_rdata;
        end
    end

    assign pc_plus4    = pc + isa_pkg::INST_SIZE;
    assign pc_target   = pc + imm;                      // jal and branches.
    assign jalr_target = {alu_result[31:1], 1'b0};

    always_comb begin
        case (opcode)
            isa_pkg::JAL:    next_pc = pc_target;
            isa_pkg::JALR:   next_pc = jalr_target;
            isa_pkg::BRANCH: next_pc = branch_taken ? pc_target : pc_plus4;
            default:         next_pc = pc_plus4;
        endcase
    end

    assign target_misaligned = next_pc[1:0] != 2'b00;

    always_comb begin
        case (src1)
            core_pkg::SRC1_PC:   alu_a = pc;
            core_pkg::SRC1_ZERO: alu_a = '0;
            default:             alu_a = rs1_data;
        endcase
        alu_b = (src2 == core_pkg::SRC2_IMM) ? imm : rs2_data;
        case (rd_sel)
            core_pkg::RD_MEM:  rd_data = load_data;
            core_pkg::RD_LINK: rd_data = pc_plus4;
            default:           rd_data = alu_result;
        endcase
    end

    core_control u_core_control (
        .clk              (clk),
        .rst              (rst),
        .opcode           (opcode),
        .illegal          (illegal),
        .target_misaligned(target_misaligned),
        .misaligned       (misaligned),
        .fetch            (fetch),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .write_ir         (write_ir),
        .write_pc         (write_pc),
        .write_rd         (write_rd),
        .trap             (trap)
    );

    inst_decode #(.NUM_REGS(NUM_REGS)) u_inst_decode (
        .ir     (ir),
        .opcode (opcode),
        .funct3 (funct3),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .imm    (imm),
        .alu_op (alu_op),
        .src1   (src1),
        .src2   (src2),
        .rd_sel (rd_sel),
        .illegal(illegal)
    );

    reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wr_data (rd_data),
        .wr_en   (write_rd),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    alu u_alu (
        .a           (alu_a),
        .b           (alu_b),
        .op          (alu_op),
        .funct3      (funct3),
        .result      (alu_result),
        .branch_taken(branch_taken)
    );

    mem_port u_mem_port (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .pc        (pc),
        .addr      (alu_result),
        .store_data(rs2_data),
        .funct3    (funct3),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_be    (mem_be),
        .mem_wdata (mem_wdata),
        .load_data (load_data),
        .misaligned(misaligned)
    );

endmodule

`default_nettype wire

//--- tb/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
    localparam logic [31:0] RES_BASE = 32'h0000_1000;
    localparam logic [31:0] LD_BASE = 32'h0000_2000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [31:0] mem_rdata = '0;
    logic mem_req, mem_we, trap;
    logic [31:0] mem_addr, mem_wdata;
    logic [3:0] mem_be;

    logic [31:0] mem [0:4095];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0] exp_be [$];
    logic [31:0] op_a, op_b, ld_word;
    int pc_w = 0;
    int res_off = 0;
    int pending = 0;
    logic built = 1'b0;
    logic rst_q = 1'b1;

    rv_core #(.NUM_REGS(32), .RESET_VECTOR(RESET_VECTOR)) u_rv_core (
        .clk(clk), .rst(rst), .mem_rdata(mem_rdata), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_be(mem_be), .mem_wdata(mem_wdata), .trap(trap)
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // word memory, writes land at the edge and read data follows a cycle later.
    always @(posedge clk) begin
        logic [31:0] rd_word;
        logic rd_en;
        rd_word = mem[mem_addr[13:2]];
        rd_en = mem_req && !mem_we;
        if (mem_req && mem_we) begin
            for (int i = 0; i < 4; i++)
                if (mem_be[i]) mem[mem_addr[13:2]][8*i +: 8] = mem_wdata[8*i +: 8];
        end
        #1;
        if (rd_en) mem_rdata <= rd_word;
    end

    always @(posedge clk) begin
        if (!rst && mem_req && mem_we) begin
            if (pending == 0) fail_now("unexpected store after the last expected one");
            if (mem_addr !== exp_addr[0])
                fail_now($sformatf("** Error mem_addr: got %h expected %h",
                                   mem_addr, exp_addr[0]));
            if (mem_be !== exp_be[0])
                fail_now($sformatf("** Error mem_be: got %h expected %h", mem_be, exp_be[0]));
            if (mem_wdata !== exp_data[0])
                fail_now($sformatf("** Error mem_wdata: got %h expected %h",
                                   mem_wdata, exp_data[0]));
            void'(exp_addr.pop_front());
            void'(exp_be.pop_front());
            void'(exp_data.pop_front());
            pending--;
        end
        if (rst_q && !rst) begin
            if (mem_req !== 1'b1 || mem_we !== 1'b0)
                fail_now("no fetch request in the first cycle after reset");
            if (mem_addr !== RESET_VECTOR)
                fail_now($sformatf("** Error mem_addr: got %h expected %h",
                                   mem_addr, RESET_VECTOR));
        end
        rst_q <= rst;
    end

    a_reset_idle: assert property (@(posedge clk) rst |-> !mem_req && !trap && !mem_we)
        else fail_now("memory request or trap seen during reset");
    a_trap_sticky: assert property (@(posedge clk) disable iff (rst) trap |=> trap)
        else fail_now("trap fell without a reset");
    a_trapped_quiet: assert property (@(posedge clk) disable iff (rst) trap |-> !mem_req)
        else fail_now("memory request issued while trapped");
    a_trap_at_end: assert property (@(posedge clk) disable iff (rst) trap |-> pending == 0)
        else fail_now("trap raised before the program finished");

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_model(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::BRANCH};
    endfunction

    function automatic logic [31:0] here();
        return 32'(pc_w) << 2;
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[pc_w] = w;
        pc_w++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_be.push_back(be);
        exp_data.push_back(data);
        pending++;
    endtask

    // stores rs2 to the next result slot, checked only when the path reaches it.
    task automatic store_result(input logic [4:0] rs2, input logic [31:0] value,
                                input logic reached);
        emit(enc_s(12'(res_off), rs2, 5'd3, isa_pkg::F3_WORD));
        if (reached) expect_store(RES_BASE + 32'(res_off), 4'hf, value);
        res_off += 4;
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit({hi[19:0], r, isa_pkg::LUI});
        emit(enc_i(v[11:0], r, 3'd0, r, isa_pkg::OP_IMM));
    endtask

    task automatic build_program();
        logic [11:0] imm;
        logic [19:0] u;
        logic [31:0] p, v, lane;
        logic [2:0] f3;
        logic alt;
        logic [4:0] rs2;
        emit({20'h1, 5'd3, isa_pkg::LUI});
        emit({20'h2, 5'd4, isa_pkg::LUI});
        load_reg(5'd1, op_a);
        load_reg(5'd2, op_b);
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = k >= 8;
            emit({alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd9, isa_pkg::OP});
            store_result(5'd9, alu_model(f3, alt, op_a, op_b), 1'b1);
        end
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'd5;
            alt = k == 8;
            imm = 12'($urandom());
            if (f3 == 3'd1 || f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
            emit(enc_i(imm, 5'd1, f3, 5'd9, isa_pkg::OP_IMM));
            store_result(5'd9, alu_model(f3, alt, op_a, {{20{imm[11]}}, imm}), 1'b1);
        end
        u = 20'($urandom());
        emit({u, 5'd9, isa_pkg::LUI});
        store_result(5'd9, {u, 12'b0}, 1'b1);
        p = here();
        emit({u, 5'd9, isa_pkg::AUIPC});
        store_result(5'd9, p + {u, 12'b0}, 1'b1);
        for (int k = 0; k < 12; k++) begin
            f3 = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2);
            rs2 = (k < 6) ? 5'd2 : 5'd1;
            v = (k < 6) ? op_b : op_a;
            emit(enc_b(13'd8, rs2, 5'd1, f3));
            store_result(5'd1, op_a, !br_model(f3, op_a, v));
        end
        p = here();
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd5, isa_pkg::JAL}); // jumps 8 bytes ahead.
        emit(32'h0);
        store_result(5'd5, p + 32'd4, 1'b1);
        p = here();
        emit({20'h0, 5'd6, isa_pkg::AUIPC});
        emit(enc_i(12'd13, 5'd6, 3'd0, 5'd7, isa_pkg::JALR)); // odd target, bit 0 dropped.
        emit(32'h0);
        store_result(5'd7, p + 32'd8, 1'b1);
        for (int k = 0; k < 13; k++) begin
            f3 = (k < 4) ? 3'd0 : (k < 8) ? 3'd4 : (k < 10) ? 3'd1 : (k < 12) ? 3'd5 : 3'd2;
            imm = (k < 8) ? 12'(k % 4) : (k < 12) ? 12'((k % 2) * 2) : 12'd0;
            lane = ld_word >> (8 * imm[1:0]);
            case (f3)
                3'd0: v = {{24{lane[7]}}, lane[7:0]};
                3'd4: v = {24'b0, lane[7:0]};
                3'd1: v = {{16{lane[15]}}, lane[15:0]};
                3'd5: v = {16'b0, lane[15:0]};
                default: v = ld_word;
            endcase
            emit(enc_i(imm, 5'd4, f3, 5'd8, isa_pkg::LOAD));
            store_result(5'd8, v, 1'b1);
        end
        for (int k = 0; k < 6; k++) begin
            imm = 12'(res_off + ((k < 4) ? k : (k - 4) * 2));
            f3 = (k < 4) ? isa_pkg::F3_BYTE : isa_pkg::F3_HALF;
            emit(enc_s(imm, 5'd1, 5'd3, f3));
            if (k < 4)
                expect_store(RES_BASE + 32'(imm), 4'b0001 << imm[1:0], {4{op_a[7:0]}});
            else
                expect_store(RES_BASE + 32'(imm), 4'b0011 << imm[1:0], {2{op_a[15:0]}});
            res_off += 4;
        end
        emit(32'h0); // final illegal instruction.
    endtask

    initial begin
        void'($urandom(32'h5472_382c));
        for (int i = 0; i < 4096; i++) mem[i] = '0;
        op_a = $urandom();
        op_b = $urandom();
        ld_word = $urandom();
        mem[LD_BASE[13:2]] = ld_word;
        build_program();
        built = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        wait (trap);
        repeat (10) @(posedge clk);
        if (pending == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_now("program ended with stores still expected");
        end
    end

    // watchdog, five cycles per instruction covers the slowest class.
    initial begin
        wait (built);
        repeat (pc_w * 5 + 100) @(posedge clk);
        fail_now("timeout waiting for the trap at the end of the program");
    end

endmodule

`default_nettype wire

//--- build.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/inst_decode.sv
verilog/alu.sv
verilog/core_control.sv
verilog/mem_port.sv
verilog/rv_core.sv
tb/rv_core_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim | grep "sim passed" \
    && exit 0 \
    || exit 1
